/* verilog.f */
design/pam_pkg.sv
design/free_bit_finder.sv
design/page_alloc_fsm.sv
design/wb_pam_regs.sv
design/pam_top.sv
tests/tb_clock_gen.sv
tests/tb_pam_top.sv

/* run.sh */
#!/bin/sh
# Build and run the page allocator testbench with Verilator

verilator --binary --timing --assert --top-module tb_pam_top -f verilog.f -o tb_pam_top_sim \
	&& ./obj_dir/tb_pam_top_sim > sim.log 2>&1 \
	|| { echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "Something failed" sim.log \
	&& { echo "Simulation reported a failure"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

/* tests/tb_pam_top.sv */
// Page allocator testbench
`timescale 1ns/1ps

module tb_pam_top
	import pam_pkg::*;
();

	localparam int RESERVED_LOW = 9;
	localparam int FREE_INIT    = NUM_PAGES - RESERVED_LOW - 1;
	// Limits for every wait loop
	localparam int ACK_LIMIT    = 16;
	localparam int POLL_LIMIT   = 40;
	localparam int RESET_LIMIT  = 20;

	logic     clk;
	logic     rst;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_adr_t  wb_adr;
	wb_data_t wb_wdata;
	wb_data_t wb_rdata;
	logic     wb_ack;

	int errors;
	int timeouts;

	// Reference model, a set bit is an allocated page
	logic [NUM_PAGES-1:0] model_map;
	int                   model_count;
	logic [15:0]          lfsr_q;

	tb_clock_gen #(
		.RESET_CYCLES (2)
	) u_clk (
		.clk_o (clk),
		.rst_o (rst)
	);

	pam_top #(
		.RESERVED_LOW (RESERVED_LOW)
	) u_dut (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_wdata),
		.wb_dat_o (wb_rdata),
		.wb_ack_o (wb_ack)
	);

	// ============================================================
	// Bus protocol checks
	// ============================================================

	// Ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
	else
	begin
		errors++;
		$display("CHECK FAILED wb_ack_o: got 0x%h, expected 0x0", wb_ack);
	end

	// No ack outside a bus cycle
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb))
	else
	begin
		errors++;
		$display("CHECK FAILED wb_ack_o: got 0x%h with wb_cyc_i 0x%h wb_stb_i 0x%h",
			wb_ack, wb_cyc, wb_stb);
	end

	// ============================================================
	// Helpers
	// ============================================================
	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One step per bit taken
	task automatic take_random_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			val = (val << 1) | int'(lfsr_q[0]);
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
		output wb_data_t rdata);
		int waited;
		waited = 0;
		rdata = '0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdata = wdata;
		@(negedge clk);
		while (!wb_ack && waited < ACK_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack)
		begin
			timeouts++;
			$display("Timeout: the bus slave never acknowledged address %0d", adr);
		end
		else
		begin
			rdata = wb_rdata;
		end
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic issue_cmd(input pam_op_t op, input page_t page);
		wb_data_t unused;
		bus_access(1'b1, REG_CMD, {16'd0, page, 6'd0, op}, unused);
	endtask

	// Poll STATUS until busy clears
	task automatic wait_idle(output wb_data_t st);
		int polls;
		polls = 0;
		bus_access(1'b0, REG_STATUS, '0, st);
		while (st[0] && polls < POLL_LIMIT)
		begin
			bus_access(1'b0, REG_STATUS, '0, st);
			polls++;
		end
		if (st[0])
		begin
			timeouts++;
			$display("Timeout: the allocator stayed busy over %0d status reads", polls);
		end
	endtask

	task automatic check_free_count;
		wb_data_t rd;
		bus_access(1'b0, REG_FREE_CNT, '0, rd);
		check_field("free_cnt", rd, 32'(model_count));
	endtask

	// ============================================================
	// Reference model
	// ============================================================
	function automatic logic page_reserved(input int p);
		return (p < RESERVED_LOW) || (p == NUM_PAGES - 1);
	endfunction

	// Lowest free page wins, page 0 on failure
	task automatic model_alloc(output page_t p, output logic fail);
		p = '0;
		fail = 1'b1;
		for (int i = 0; i < NUM_PAGES; i++)
		begin
			if (fail && !page_reserved(i) && !model_map[i])
			begin
				p = page_t'(i);
				fail = 1'b0;
			end
		end
		if (!fail)
		begin
			model_map[p] = 1'b1;
			model_count--;
		end
	endtask

	task automatic model_free(input page_t p);
		if (!page_reserved(int'(p)) && model_map[p])
		begin
			model_map[p] = 1'b0;
			model_count++;
		end
	endtask

	task automatic model_free_all;
		model_map = '0;
		model_count = FREE_INIT;
	endtask

	// ============================================================
	// Command sequences
	// ============================================================
	task automatic do_alloc;
		wb_data_t st;
		page_t    exp_page;
		logic     exp_fail;
		issue_cmd(OP_ALLOC, 8'd0);
		wait_idle(st);
		model_alloc(exp_page, exp_fail);
		check_field("status.page", 32'(st[15:8]), 32'(exp_page));
		check_field("status.fail", 32'(st[1]), 32'(exp_fail));
		check_free_count();
	endtask

	task automatic do_free(input page_t p);
		wb_data_t st;
		issue_cmd(OP_FREE, p);
		wait_idle(st);
		model_free(p);
		check_free_count();
	endtask

	task automatic do_free_all;
		wb_data_t st;
		issue_cmd(OP_FREEALL, 8'd0);
		wait_idle(st);
		model_free_all();
		check_free_count();
	endtask

	// Second command lands while the allocation is still running
	// A gap of 3 puts its request on the last busy edge of a word 0 allocation
	task automatic alloc_with_dropped(input pam_op_t op, input page_t p, input int gap);
		wb_data_t st;
		page_t    exp_page;
		logic     exp_fail;
		issue_cmd(OP_ALLOC, 8'd0);
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
		issue_cmd(op, p);
		wait_idle(st);
		model_alloc(exp_page, exp_fail);
		check_field("status.page", 32'(st[15:8]), 32'(exp_page));
		check_field("status.fail", 32'(st[1]), 32'(exp_fail));
		check_free_count();
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin
		wb_data_t rd;
		int       waited;
		int       r;
		int       guard;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		errors = 0;
		timeouts = 0;
		lfsr_q = 16'd47;
		model_free_all();

		waited = 0;
		while (rst !== 1'b0 && waited < RESET_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (rst !== 1'b0)
		begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		@(posedge clk);
		#1;

		// Map clear after reset
		wait_idle(rd);
		check_field("status", rd, 32'd0);
		check_free_count();
		bus_access(1'b0, REG_CMD, '0, rd);
		check_field("cmd read", rd, 32'd0);

		// Ascending allocations from the first unreserved page
		repeat (20)
		begin
			do_alloc();
		end

		// Random frees, some land on pages that are already free
		repeat (12)
		begin
			take_random_bits(5, r);
			do_free(page_t'(RESERVED_LOW + r));
		end
		do_free(8'd0);
		do_free(page_t'(RESERVED_LOW - 1));
		do_free(8'd255);
		repeat (6)
		begin
			do_alloc();
		end

		// Read-only writes and a no-op command change nothing
		bus_access(1'b1, REG_STATUS, 32'hffff_ffff, rd);
		bus_access(1'b1, REG_FREE_CNT, 32'h0000_0000, rd);
		issue_cmd(OP_NONE, 8'd20);
		check_free_count();

		// Fill the map, then one allocation too many
		guard = 0;
		while (model_count > 0 && guard < NUM_PAGES)
		begin
			do_alloc();
			guard++;
		end
		do_alloc();

		// Free all, allocation restarts at the bottom
		do_free_all();
		do_alloc();

		// Commands while busy are lost
		alloc_with_dropped(OP_FREE, page_t'(RESERVED_LOW), 0);
		alloc_with_dropped(OP_FREE, page_t'(RESERVED_LOW), 3);
		alloc_with_dropped(OP_FREEALL, 8'd0, 3);
		alloc_with_dropped(OP_ALLOC, 8'd0, 3);

		$display("Closing: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int RESET_CYCLES = 2
)
(
	output logic clk_o,
	output logic rst_o
);

	// 10 ns period, low at time zero
	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#5 clk_o = ~clk_o;
		end
	end

	// Synchronous reset held over the first rising edges
	initial
	begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES)
		begin
			@(posedge clk_o);
		end
		#1 rst_o = 1'b0;
	end

endmodule

/* design/pam_top.sv */
// Page allocator top level
`timescale 1ns/1ps

module pam_top
	import pam_pkg::*;
#(
	// Pages 0 up to RESERVED_LOW-1 are never handed out
	parameter int RESERVED_LOW = 9
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     wb_cyc_i,
	input  logic     wb_stb_i,
	input  logic     wb_we_i,
	input  wb_adr_t  wb_adr_i,
	input  wb_data_t wb_dat_i,
	output wb_data_t wb_dat_o,
	output logic     wb_ack_o
);

	// Slave to allocator and back
	pam_cmd_t    cmd;
	pam_status_t status;

	// ============================================================
	// Bus slave
	// ============================================================
	wb_pam_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.status_i (status),
		.cmd_o    (cmd)
	);

	// ============================================================
	// Allocator
	// ============================================================
	page_alloc_fsm #(
		.RESERVED_LOW (RESERVED_LOW)
	) u_alloc (
		.clk      (clk),
		.rst      (rst),
		.cmd_i    (cmd),
		.status_o (status)
	);

endmodule

/* design/wb_pam_regs.sv */
// Wishbone register slave
`timescale 1ns/1ps

module wb_pam_regs
	import pam_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  wb_adr_t     wb_adr_i,
	input  wb_data_t    wb_dat_i,
	output wb_data_t    wb_dat_o,
	output logic        wb_ack_o,
	input  pam_status_t status_i,
	output pam_cmd_t    cmd_o
);

	logic     ack_q;
	logic     req;
	logic     cmd_wr;
	logic     cmd_take;
	pam_op_t  wr_op;
	wb_data_t rd_mux;
	wb_data_t dat_q;
	pam_cmd_t cmd_q;

	// ============================================================
	// Bus handshake
	// ============================================================

	// New cycle seen, not yet acknowledged
	assign req = wb_cyc_i & wb_stb_i & !ack_q;

	// Single cycle ack, the master drops stb after it
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack_q <= 1'b0;
		end
		else
		begin
			ack_q <= req;
		end
	end

	// ============================================================
	// Command decode
	// ============================================================
	assign wr_op  = pam_op_t'(wb_dat_i[1:0]);
	assign cmd_wr = req & wb_we_i & (wb_adr_i == REG_CMD);
	// Drop no-ops and anything arriving while the allocator works
	assign cmd_take = cmd_wr & (wr_op != OP_NONE) & !status_i.busy;

	// Strobe lines up with the ack cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cmd_q <= '0;
		end
		else
		begin
			cmd_q.valid <= cmd_take;
			if (cmd_take)
			begin
				cmd_q.op   <= wr_op;
				cmd_q.page <= wb_dat_i[15:8];
			end
		end
	end

	// ============================================================
	// Read path
	// ============================================================
	always_comb
	begin
		unique case (wb_adr_i)
			REG_STATUS:   rd_mux = {16'd0, status_i.page, 6'd0, status_i.fail, status_i.busy};
			REG_FREE_CNT: rd_mux = wb_data_t'(status_i.free_cnt);
			// CMD and the spare address read as zero
			default:      rd_mux = '0;
		endcase
	end

	// Sampled on the request, presented with ack
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			dat_q <= rd_mux;
		end
	end

	assign wb_dat_o = dat_q;
	assign wb_ack_o = ack_q;
	assign cmd_o    = cmd_q;

endmodule

/* design/page_alloc_fsm.sv */
// Page bitmap and allocation FSM
`timescale 1ns/1ps

module page_alloc_fsm
	import pam_pkg::*;
#(
	parameter int RESERVED_LOW = 9
)
(
	input  logic        clk,
	input  logic        rst,
	input  pam_cmd_t    cmd_i,
	output pam_status_t status_o
);

	// Free pages once the map is empty, low block and top page excluded
	localparam count_t    FREE_INIT = count_t'(NUM_PAGES - RESERVED_LOW - 1);
	localparam word_idx_t LAST_WORD = word_idx_t'(NUM_WORDS - 1);
	// Reserved low pages, all of them live in word 0
	localparam map_word_t LOW_MASK  = map_word_t'((64'd1 << RESERVED_LOW) - 64'd1);

	typedef enum logic [3:0] {
		CLEAR,
		IDLE,
		ALLOC_READ,
		ALLOC_SCAN,
		ALLOC_COMMIT,
		ALLOC_FAIL,
		FREE_READ,
		FREE_MODIFY,
		FREE_WRITE
	} state_t;

	state_t    state_q;
	word_idx_t word_q;
	logic      commit_ph_q;
	logic      free_ok_q;
	logic      fail_q;
	page_t     result_q;
	count_t    count_q;

	// Bitmap and working word
	map_word_t bitmap [NUM_WORDS];
	map_word_t map_q;
	bit_idx_t  bit_q;

	map_word_t masked_word;
	bit_idx_t  find_bit;
	logic      find_full;
	logic      page_reserved;

	// Stored word with the reserved pages forced to taken
	always_comb
	begin
		masked_word = bitmap[word_q];
		if (word_q == '0)
		begin
			masked_word = masked_word | LOW_MASK;
		end
		if (word_q == LAST_WORD)
		begin
			masked_word[31] = 1'b1;
		end
	end

	// Pages that a free command must never touch
	assign page_reserved = (int'(cmd_i.page) < RESERVED_LOW) ||
		(int'(cmd_i.page) == NUM_PAGES - 1);

	free_bit_finder u_finder (
		.map_i  (map_q),
		.bit_o  (find_bit),
		.full_o (find_full)
	);

	// ============================================================
	// Control and counters
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q     <= CLEAR;
			word_q      <= '0;
			commit_ph_q <= 1'b0;
			free_ok_q   <= 1'b0;
			fail_q      <= 1'b0;
			result_q    <= '0;
			count_q     <= FREE_INIT;
		end
		else
		begin
			unique case (state_q)
				// One word per cycle, also used by free all
				CLEAR:
				begin
					word_q <= word_q + 1'b1;
					if (word_q == LAST_WORD)
					begin
						state_q <= IDLE;
					end
				end
				IDLE:
				begin
					if (cmd_i.valid)
					begin
						unique case (cmd_i.op)
							OP_ALLOC:
							begin
								word_q  <= '0;
								fail_q  <= 1'b0;
								state_q <= ALLOC_READ;
							end
							OP_FREE:
							begin
								word_q    <= cmd_i.page[7:5];
								free_ok_q <= !page_reserved;
								state_q   <= FREE_READ;
							end
							OP_FREEALL:
							begin
								word_q  <= '0;
								fail_q  <= 1'b0;
								count_q <= FREE_INIT;
								state_q <= CLEAR;
							end
							default:
							begin
								state_q <= IDLE;
							end
						endcase
					end
				end
				ALLOC_READ:
				begin
					state_q <= ALLOC_SCAN;
				end
				ALLOC_SCAN:
				begin
					if (!find_full)
					begin
						commit_ph_q <= 1'b0;
						state_q     <= ALLOC_COMMIT;
					end
					else if (word_q == LAST_WORD)
					begin
						state_q <= ALLOC_FAIL;
					end
					else
					begin
						word_q  <= word_q + 1'b1;
						state_q <= ALLOC_READ;
					end
				end
				// Phase 0 sets the bit, phase 1 writes back
				ALLOC_COMMIT:
				begin
					commit_ph_q <= 1'b1;
					if (commit_ph_q)
					begin
						result_q <= {word_q, bit_q};
						count_q  <= count_q - 1'b1;
						state_q  <= IDLE;
					end
				end
				// Page 0 is reserved so it doubles as the fail result
				ALLOC_FAIL:
				begin
					fail_q   <= 1'b1;
					result_q <= '0;
					state_q  <= IDLE;
				end
				FREE_READ:
				begin
					state_q <= FREE_MODIFY;
				end
				FREE_MODIFY:
				begin
					// Already free means nothing to give back
					free_ok_q <= free_ok_q & map_q[bit_q];
					state_q   <= FREE_WRITE;
				end
				FREE_WRITE:
				begin
					if (free_ok_q)
					begin
						count_q <= count_q + 1'b1;
					end
					state_q <= IDLE;
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// ============================================================
	// Bitmap datapath
	// ============================================================
	always_ff @(posedge clk)
	begin
		unique case (state_q)
			CLEAR:
			begin
				bitmap[word_q] <= '0;
			end
			IDLE:
			begin
				bit_q <= cmd_i.page[4:0];
			end
			ALLOC_READ:
			begin
				map_q <= masked_word;
			end
			ALLOC_SCAN:
			begin
				bit_q <= find_bit;
			end
			ALLOC_COMMIT:
			begin
				// Reread the raw word so reserved bits stay clear in storage
				if (!commit_ph_q)
				begin
					map_q <= bitmap[word_q] | (map_word_t'(1) << bit_q);
				end
				else
				begin
					bitmap[word_q] <= map_q;
				end
			end
			FREE_READ:
			begin
				map_q <= bitmap[word_q];
			end
			FREE_MODIFY:
			begin
				if (free_ok_q)
				begin
					map_q[bit_q] <= 1'b0;
				end
			end
			FREE_WRITE:
			begin
				bitmap[word_q] <= map_q;
			end
			default:
			begin
			end
		endcase
	end

	// Busy covers every state except IDLE
	assign status_o.busy     = (state_q != IDLE);
	assign status_o.fail     = fail_q;
	assign status_o.page     = result_q;
	assign status_o.free_cnt = count_q;

endmodule

/* design/free_bit_finder.sv */
// Lowest free bit finder
`timescale 1ns/1ps

module free_bit_finder
	import pam_pkg::*;
(
	input  map_word_t map_i,
	output bit_idx_t  bit_o,
	output logic      full_o
);

	// ============================================================
	// Priority search
	// ============================================================

	// Walk from the top bit down so the last hit is the lowest zero
	// Lowest page first keeps allocation deterministic
	always_comb
	begin
		bit_o = '0;
		for (int i = 31; i >= 0; i--)
		begin
			if (!map_i[i])
			begin
				bit_o = bit_idx_t'(i);
			end
		end
	end

	// Every page in this word is taken
	// bit_o is then meaningless and stays at 0
	assign full_o = &map_i;

endmodule

/* design/pam_pkg.sv */
// Page allocator shared types
package pam_pkg;

	// ============================================================
	// Sizes of the page map
	// ============================================================
	localparam int NUM_PAGES = 256;
	localparam int NUM_WORDS = 8;

	// Page number, split as word index over bit position
	typedef logic [7:0]  page_t;
	typedef logic [2:0]  word_idx_t;
	typedef logic [4:0]  bit_idx_t;
	// One bitmap word, a set bit marks an allocated page
	typedef logic [31:0] map_word_t;
	// Free pages, wide enough to hold NUM_PAGES
	typedef logic [8:0]  count_t;

	// Bus side widths
	typedef logic [1:0]  wb_adr_t;
	typedef logic [31:0] wb_data_t;

	// ============================================================
	// Commands and status
	// ============================================================
	typedef enum logic [1:0] {
		OP_NONE    = 2'd0,
		OP_ALLOC   = 2'd1,
		OP_FREE    = 2'd2,
		OP_FREEALL = 2'd3
	} pam_op_t;

	// Command strobe from the bus slave, valid is high for one cycle
	typedef struct packed {
		logic    valid;
		pam_op_t op;
		page_t   page;
	} pam_cmd_t;

	// Allocator state seen by the bus slave
	typedef struct packed {
		logic   busy;
		logic   fail;
		page_t  page;
		count_t free_cnt;
	} pam_status_t;

	// Word addresses of the registers
	localparam wb_adr_t REG_CMD      = 2'd0;
	localparam wb_adr_t REG_STATUS   = 2'd1;
	localparam wb_adr_t REG_FREE_CNT = 2'd2;

endpackage
